// File: hdl/nt_config.svh
// Name-table store configuration.
// Sizes shared by the package, the queues and the RAM.

`ifndef NT_CONFIG_SVH
`define NT_CONFIG_SVH

// Word address width, covering the tile-name and attribute areas.
`define NT_ADDR_W 9

// Number of 32-bit words in the RAM.
`define NT_DEPTH 512

// Bytes per RAM word.
`define NT_BYTES 4

// Queue depth per writer.
// The sender starts with this many credits after reset.
`define NT_CREDITS 2

`endif

// File: hdl/ntPkg.sv
// Name-table store types.
// Write request format and write source encoding.

`include "nt_config.svh"

package ntPkg;

    // One byte-enabled word write.
    // byteEn[3] covers data[7:0] and byteEn[0] covers data[31:24].
    typedef struct packed {
        logic [`NT_ADDR_W-1:0]   addr;
        logic [`NT_BYTES-1:0]    byteEn;
        logic [8*`NT_BYTES-1:0]  data;
    } ntWriteReq;

    // Arbiter grant, also carried to the RAM.
    typedef enum logic [1:0] {
        none = 2'd0,
        cpu  = 2'd1,
        name = 2'd2,
        attr = 2'd3
    } ntSource;

endpackage

// File: hdl/creditFifo.sv
// Credit-controlled request queue.
// Returns one credit pulse per entry that leaves.

`timescale 1ns/1ns

`include "nt_config.svh"

module creditFifo #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk_sel,
    input  logic    reset,
    input  logic    push,
    input  payloadT pushData,
    output logic    notEmpty,
    output payloadT head,
    input  logic    pop,
    output logic    credit
);

    localparam int PTR_W = (`NT_CREDITS > 1) ? $clog2(`NT_CREDITS) : 1;
    localparam int CNT_W = $clog2(`NT_CREDITS + 1);

    payloadT            entries [0:`NT_CREDITS-1];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`NT_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign head     = entries[rdPtr];

    always_ff @(posedge clk_sel) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk_sel) begin
        if (reset) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop; // One pulse per released entry.
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/writeArbiter.sv
// Fixed-priority write arbiter.
// Pops one queue per cycle into the single RAM write port.

`timescale 1ns/1ns

module writeArbiter (
    input  logic              cpuNotEmpty,
    input  logic              nameNotEmpty,
    input  logic              attrNotEmpty,
    input  ntPkg::ntWriteReq  cpuHead,
    input  ntPkg::ntWriteReq  nameHead,
    input  ntPkg::ntWriteReq  attrHead,
    output logic              cpuPop,
    output logic              namePop,
    output logic              attrPop,
    output logic              wrEn,
    output ntPkg::ntWriteReq  wrReq,
    output ntPkg::ntSource    wrSource
);

    import ntPkg::*;

    always_comb begin
        cpuPop   = 1'b0;
        namePop  = 1'b0;
        attrPop  = 1'b0;
        wrReq    = cpuHead;
        wrSource = none;
        // cpu first, then name loader, then attribute loader.
        if (cpuNotEmpty) begin
            cpuPop   = 1'b1;
            wrSource = cpu;
        end else if (nameNotEmpty) begin
            namePop  = 1'b1;
            wrReq    = nameHead;
            wrSource = name;
        end else if (attrNotEmpty) begin
            attrPop  = 1'b1;
            wrReq    = attrHead;
            wrSource = attr;
        end
    end

    assign wrEn = cpuPop | namePop | attrPop;

endmodule

// File: hdl/nameTableRam.sv
// Background name-table memory, 512 words of 32 bits.
// One byte-enabled write port and three registered read ports.

`timescale 1ns/1ns

`include "nt_config.svh"

module nameTableRam (
    input  logic                   clk_sel,
    input  logic                   wrEn,
    input  ntPkg::ntWriteReq       wrReq,
    input  ntPkg::ntSource         wrSource,
    input  logic [`NT_ADDR_W-1:0]  cpuRdAddr,
    input  logic [`NT_ADDR_W-1:0]  tileNameAddr,
    input  logic [`NT_ADDR_W-1:0]  attrAddr,
    output logic [31:0]            cpuRdData,
    output logic [31:0]            tileNameData,
    output logic [31:0]            attrData
);

    // wrSource is observed by the bound assertions only.

    logic [8*`NT_BYTES-1:0] mem [0:`NT_DEPTH-1];

    // Byte enable bit b writes the byte counted from the top of the word.
    always_ff @(posedge clk_sel) begin
        if (wrEn) begin
            for (int b = 0; b < `NT_BYTES; b++) begin
                if (wrReq.byteEn[b]) begin
                    mem[wrReq.addr][8*(`NT_BYTES-1-b) +: 8] <=
                        wrReq.data[8*(`NT_BYTES-1-b) +: 8];
                end
            end
        end
    end

    // Read-first, a same-edge write shows up on the next read.
    always_ff @(posedge clk_sel) begin
        cpuRdData <= mem[cpuRdAddr]; // CPU readback.
    end

    always_ff @(posedge clk_sel) begin
        tileNameData <= mem[tileNameAddr]; // Tile name fetch.
    end

    always_ff @(posedge clk_sel) begin
        attrData <= mem[attrAddr]; // Attribute fetch.
    end

endmodule

// File: hdl/nameTableTop.sv
// Name-table store top level.
// Three credit queues feed the arbiter, which writes the shared RAM.

`timescale 1ns/1ns

`include "nt_config.svh"

module nameTableTop (
    input  logic                   clk_sel,
    input  logic                   reset,
    input  logic                   cpuWrValid,
    input  ntPkg::ntWriteReq       cpuWrReq,
    output logic                   cpuWrCredit,
    input  logic                   nameWrValid,
    input  ntPkg::ntWriteReq       nameWrReq,
    output logic                   nameWrCredit,
    input  logic                   attrWrValid,
    input  ntPkg::ntWriteReq       attrWrReq,
    output logic                   attrWrCredit,
    input  logic [`NT_ADDR_W-1:0]  cpuRdAddr,
    input  logic [`NT_ADDR_W-1:0]  tileNameAddr,
    input  logic [`NT_ADDR_W-1:0]  attrAddr,
    output logic [31:0]            cpuRdData,
    output logic [31:0]            tileNameData,
    output logic [31:0]            attrData
);

    import ntPkg::*;

    logic       cpuNotEmpty, nameNotEmpty, attrNotEmpty;
    logic       cpuPop, namePop, attrPop;
    ntWriteReq  cpuHead, nameHead, attrHead;
    logic       wrEn;
    ntWriteReq  wrReq;
    ntSource    wrSource;

    creditFifo #(.payloadT(ntWriteReq)) i_cpuFifo (
        .clk_sel(clk_sel), .reset(reset), .push(cpuWrValid), .pushData(cpuWrReq),
        .notEmpty(cpuNotEmpty), .head(cpuHead), .pop(cpuPop), .credit(cpuWrCredit)
    );

    creditFifo #(.payloadT(ntWriteReq)) i_nameFifo (
        .clk_sel(clk_sel), .reset(reset), .push(nameWrValid), .pushData(nameWrReq),
        .notEmpty(nameNotEmpty), .head(nameHead), .pop(namePop), .credit(nameWrCredit)
    );

    creditFifo #(.payloadT(ntWriteReq)) i_attrFifo (
        .clk_sel(clk_sel), .reset(reset), .push(attrWrValid), .pushData(attrWrReq),
        .notEmpty(attrNotEmpty), .head(attrHead), .pop(attrPop), .credit(attrWrCredit)
    );

    writeArbiter i_arb (
        .cpuNotEmpty(cpuNotEmpty), .nameNotEmpty(nameNotEmpty), .attrNotEmpty(attrNotEmpty),
        .cpuHead(cpuHead), .nameHead(nameHead), .attrHead(attrHead),
        .cpuPop(cpuPop), .namePop(namePop), .attrPop(attrPop),
        .wrEn(wrEn), .wrReq(wrReq), .wrSource(wrSource)
    );

    nameTableRam i_ram (
        .clk_sel(clk_sel), .wrEn(wrEn), .wrReq(wrReq), .wrSource(wrSource),
        .cpuRdAddr(cpuRdAddr), .tileNameAddr(tileNameAddr), .attrAddr(attrAddr),
        .cpuRdData(cpuRdData), .tileNameData(tileNameData), .attrData(attrData)
    );

endmodule

// File: sim/nameTable_assertions.sv
// Protocol checks for the name-table store.
// Bound to every queue and to the top level for the arbiter.

`timescale 1ns/1ns

`include "nt_config.svh"

module nameTable_assertions (
    input logic            clk_sel,
    input logic            reset,
    input logic            push,
    input logic            pop,
    input logic            full,
    input logic            empty,
    input logic [2:0]      pops,
    input logic            wrEn,
    input ntPkg::ntSource  wrSource
);

    import ntPkg::*;

    int failCount = 0;

    noPushWhenFull: assert property (@(posedge clk_sel) disable iff (reset) push |-> !full)
        else begin
            $error("Write pushed into a full queue, sender had no credit.");
            failCount++;
        end

    noPopWhenEmpty: assert property (@(posedge clk_sel) disable iff (reset) pop |-> !empty)
        else begin
            $error("Pop from an empty queue.");
            failCount++;
        end

    onePopPerCycle: assert property (@(posedge clk_sel) disable iff (reset) $onehot0(pops))
        else begin
            $error("More than one queue popped in one cycle.");
            failCount++;
        end

    sourceMatchesEnable: assert property (@(posedge clk_sel) disable iff (reset)
        ((wrSource == none) == !wrEn))
        else begin
            $error("Write source and write enable disagree.");
            failCount++;
        end

endmodule

bind creditFifo nameTable_assertions i_fifoChecks (
    .clk_sel(clk_sel), .reset(reset), .push(push), .pop(pop),
    .full(count == `NT_CREDITS), .empty(count == '0),
    .pops({2'b00, pop}), .wrEn(1'b0), .wrSource(ntPkg::none)
);

bind nameTableTop nameTable_assertions i_arbChecks (
    .clk_sel(clk_sel), .reset(reset), .push(1'b0), .pop(1'b0),
    .full(1'b0), .empty(1'b1),
    .pops({cpuPop, namePop, attrPop}), .wrEn(wrEn), .wrSource(wrSource)
);

// File: sim/nameTableTb.sv
// Testbench for the name-table store.
// Credit-respecting writers, shadow memory model and readback checks.

`timescale 1ns/1ns

`include "nt_config.svh"

module nameTableTb;

    import ntPkg::*;

    localparam int NUM_SRC       = 3;
    localparam int NUM_ROWS      = 8;
    localparam int FLOW_LEN      = 6;
    localparam int RANDOM_WRITES = 200;
    localparam int CYCLE_LIMIT   = NUM_ROWS * (`NT_CREDITS + 6) + RANDOM_WRITES * 4
                                   + `NT_DEPTH * 8 + 500;

    typedef struct {
        string                  name;
        logic                   readPhase;  // Read back after the writes.
        logic [2:0]             en;         // Bit 0 cpu, bit 1 name, bit 2 attr.
        ntWriteReq              cpuReq;
        ntWriteReq              nameReq;
        ntWriteReq              attrReq;
        logic [`NT_ADDR_W-1:0]  rdAddr;
        logic [31:0]            expected;
    } rowT;

    logic                   clk_sel;
    logic                   reset;
    logic [2:0]             wrValid;
    ntWriteReq              wrReq [NUM_SRC];
    wire  [2:0]             wrCredit;
    logic [`NT_ADDR_W-1:0]  rdAddr;
    wire  [31:0]            cpuRdData, tileNameData, attrData;

    rowT          rows [NUM_ROWS];
    int           credits [NUM_SRC];
    int           sent [NUM_SRC];
    int           returned [NUM_SRC];
    logic [31:0]  shadow [`NT_DEPTH];
    logic         touched [`NT_DEPTH];
    logic [31:0]  lfsrState;
    int           mismatchCount;
    int           errorCount;

    nameTableTop i_dut (
        .clk_sel(clk_sel), .reset(reset),
        .cpuWrValid(wrValid[0]), .cpuWrReq(wrReq[0]), .cpuWrCredit(wrCredit[0]),
        .nameWrValid(wrValid[1]), .nameWrReq(wrReq[1]), .nameWrCredit(wrCredit[1]),
        .attrWrValid(wrValid[2]), .attrWrReq(wrReq[2]), .attrWrCredit(wrCredit[2]),
        .cpuRdAddr(rdAddr), .tileNameAddr(rdAddr), .attrAddr(rdAddr),
        .cpuRdData(cpuRdData), .tileNameData(tileNameData), .attrData(attrData)
    );

    initial begin
        clk_sel = 1'b0;
        forever #4 clk_sel = ~clk_sel;
    end

    initial begin
        int cycleCount;
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk_sel);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits      = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic ntWriteReq makeReq(input logic [`NT_ADDR_W-1:0] addr,
                                          input logic [3:0] be, input logic [31:0] data);
        ntWriteReq req;
        req.addr   = addr;
        req.byteEn = be;
        req.data   = data;
        return req;
    endfunction

    function automatic logic [31:0] fillWord(input int a);
        logic [8:0] ad;
        ad = a[8:0];
        return {ad, 7'h35, ~ad, 7'h4B};
    endfunction

    // Lane 0 is bits 7..0 and is enabled by byteEn[3].
    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input ntWriteReq req);
        logic [31:0] word;
        word = old;
        for (int lane = 0; lane < `NT_BYTES; lane++) begin
            if (req.byteEn[`NT_BYTES-1-lane]) begin
                word[8*lane +: 8] = req.data[8*lane +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic allCreditsHome();
        return credits[0] == `NT_CREDITS && credits[1] == `NT_CREDITS
            && credits[2] == `NT_CREDITS;
    endfunction

    function automatic int countAssertionFailures();
        return i_dut.i_cpuFifo.i_fifoChecks.failCount
            + i_dut.i_nameFifo.i_fifoChecks.failCount
            + i_dut.i_attrFifo.i_fifoChecks.failCount
            + i_dut.i_arbChecks.failCount;
    endfunction

    // One clock edge with credit bookkeeping. Valids drop unless driven again.
    task automatic stepClock();
        @(posedge clk_sel);
        for (int s = 0; s < NUM_SRC; s++) begin
            if (wrCredit[s]) begin
                assert (credits[s] < `NT_CREDITS) else begin
                    $display("Source %0d returned a credit with no write outstanding", s);
                    errorCount++;
                end
                credits[s]++;
                returned[s]++;
            end
            if (wrValid[s]) begin
                credits[s]--;
            end
            wrValid[s] <= 1'b0;
        end
    endtask

    task automatic driveWrite(input int s, input ntWriteReq req);
        wrValid[s] <= 1'b1;
        wrReq[s]   <= req;
        sent[s]++;
        shadow[req.addr]  = mergeBytes(shadow[req.addr], req); // Same-edge order cpu, name, attr.
        touched[req.addr] = 1'b1;
    endtask

    task automatic drainCredits();
        stepClock();
        while (!allCreditsHome()) begin
            stepClock();
        end
    endtask

    task automatic checkRead(input string testName, input logic [`NT_ADDR_W-1:0] addr,
                             input logic [31:0] expected);
        logic [31:0] got [NUM_SRC];
        string       portName [NUM_SRC] = '{"cpuRdData", "tileNameData", "attrData"};
        rdAddr <= addr;
        stepClock();
        stepClock();
        got[0] = cpuRdData;
        got[1] = tileNameData;
        got[2] = attrData;
        for (int p = 0; p < NUM_SRC; p++) begin
            assert (got[p] === expected) else begin
                $display("MISMATCH %s %s addr %03h: expected %08h, actual %08h",
                         testName, portName[p], addr, expected, got[p]);
                mismatchCount++;
            end
        end
    endtask

    task automatic checkCreditBalance(input string testName);
        for (int s = 0; s < NUM_SRC; s++) begin
            assert (sent[s] == returned[s]) else begin
                $display("%s: source %0d sent %0d writes but got %0d credits back",
                         testName, s, sent[s], returned[s]);
                errorCount++;
            end
        end
    endtask

    task automatic runCreditFlow();
        int        flowSent [NUM_SRC];
        int        iter;
        ntWriteReq req;
        flowSent = '{0, 0, 0};
        iter     = 0;
        while (flowSent[0] < FLOW_LEN || flowSent[1] < FLOW_LEN || flowSent[2] < FLOW_LEN) begin
            stepClock();
            iter++;
            if (iter == 3) begin
                assert (credits[0] == 0 && credits[1] == 0 && credits[2] == 0) else begin
                    $display("credit flow: writers still hold credits after back-to-back writes");
                    errorCount++;
                end
            end
            for (int s = 0; s < NUM_SRC; s++) begin
                if (credits[s] > 0 && flowSent[s] < FLOW_LEN) begin
                    req = makeReq(9'h180 + 9'(16 * s + flowSent[s]), 4'hF, takeBits(32));
                    driveWrite(s, req);
                    flowSent[s]++;
                end
            end
        end
        drainCredits();
        checkCreditBalance("credit flow");
    endtask

    task automatic runRandomTraffic();
        int          count;
        int          s;
        logic [31:0] bits;
        ntWriteReq   req;
        count = 0;
        while (count < RANDOM_WRITES) begin
            stepClock();
            bits       = takeBits(`NT_ADDR_W);
            req.addr   = bits[`NT_ADDR_W-1:0];
            bits       = takeBits(`NT_BYTES);
            req.byteEn = bits[`NT_BYTES-1:0];
            req.data   = takeBits(32);
            s = req.addr % NUM_SRC; // One owner per address keeps write order.
            if (credits[s] > 0) begin
                driveWrite(s, req);
                count++;
            end
        end
        drainCredits();
    endtask

    initial begin
        reset     = 1'b1;
        wrValid   = '0;
        rdAddr    = '0;
        lfsrState = 32'hecb3;
        mismatchCount = 0;
        errorCount    = 0;
        for (int s = 0; s < NUM_SRC; s++) begin
            wrReq[s]    = '0;
            credits[s]  = `NT_CREDITS;
            sent[s]     = 0;
            returned[s] = 0;
        end

        rows[0] = '{"merge base", 1'b0, 3'b001, makeReq(9'h020, 4'hF, 32'h11223344), '0, '0,
                    9'h020, 32'h11223344};
        rows[1] = '{"merge be3", 1'b1, 3'b010, '0, makeReq(9'h020, 4'b1000, 32'hAABBCCDD), '0,
                    9'h020, 32'h112233DD};
        rows[2] = '{"merge be0", 1'b1, 3'b100, '0, '0, makeReq(9'h020, 4'b0001, 32'hEEFF0011),
                    9'h020, 32'hEE2233DD};
        rows[3] = '{"merge be2 be1", 1'b1, 3'b001, makeReq(9'h020, 4'b0110, 32'h99887766),
                    '0, '0, 9'h020, 32'hEE8877DD};
        rows[4] = '{"prio partial", 1'b1, 3'b111, makeReq(9'h055, 4'hF, 32'h01020304),
                    makeReq(9'h055, 4'b0011, 32'hA1A2A3A4),
                    makeReq(9'h055, 4'b0101, 32'hB1B2B3B4), 9'h055, 32'hB1A2B304};
        rows[5] = '{"prio full", 1'b1, 3'b111, makeReq(9'h056, 4'hF, 32'h10101010),
                    makeReq(9'h056, 4'hF, 32'h20202020),
                    makeReq(9'h056, 4'hF, 32'h30303030), 9'h056, 32'h30303030};
        rows[6] = '{"prio no attr", 1'b1, 3'b011, makeReq(9'h057, 4'hF, 32'hCAFEF00D),
                    makeReq(9'h057, 4'b1000, 32'h000000EE), '0, 9'h057, 32'hCAFEF0EE};
        rows[7] = '{"prio no cpu", 1'b1, 3'b110, '0, makeReq(9'h058, 4'hF, 32'h55667788),
                    makeReq(9'h058, 4'b1000, 32'h00000099), 9'h058, 32'h55667799};

        repeat (3) @(posedge clk_sel);
        reset <= 1'b0;

        repeat (4) stepClock();
        assert (wrCredit == 3'b000) else begin
            $display("reset state: a credit output is high before any write");
            errorCount++;
        end

        for (int a = 0; a < `NT_DEPTH; a++) begin
            stepClock();
            while (credits[0] == 0) begin
                stepClock();
            end
            driveWrite(0, makeReq(a[`NT_ADDR_W-1:0], 4'hF, fillWord(a)));
        end
        drainCredits();
        for (int a = 0; a < `NT_DEPTH; a++) begin
            checkRead("fill", a[`NT_ADDR_W-1:0], fillWord(a));
        end
        touched = '{default: 1'b0};

        foreach (rows[r]) begin
            stepClock();
            if (rows[r].en[0]) driveWrite(0, rows[r].cpuReq);
            if (rows[r].en[1]) driveWrite(1, rows[r].nameReq);
            if (rows[r].en[2]) driveWrite(2, rows[r].attrReq);
            drainCredits();
            if (rows[r].readPhase) begin
                checkRead(rows[r].name, rows[r].rdAddr, rows[r].expected);
            end
        end

        runCreditFlow();
        runRandomTraffic();
        for (int a = 0; a < `NT_DEPTH; a++) begin
            if (touched[a]) begin
                checkRead("random", a[`NT_ADDR_W-1:0], shadow[a]);
            end
        end
        checkCreditBalance("end of run");
        errorCount += countAssertionFailures();

        $display("Summary: %0d mismatches, %0d other errors", mismatchCount, errorCount);
        if (mismatchCount == 0 && errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/ntPkg.sv
hdl/creditFifo.sv
hdl/writeArbiter.sv
hdl/nameTableRam.sv
hdl/nameTableTop.sv
sim/nameTable_assertions.sv
sim/nameTableTb.sv

// File: Bender.yml
package:
  name: name_table_store

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ntPkg.sv
      - hdl/creditFifo.sv
      - hdl/writeArbiter.sv
      - hdl/nameTableRam.sv
      - hdl/nameTableTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/nameTable_assertions.sv
      - sim/nameTableTb.sv
